// File: hw/rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B // LUI and the JAL link value.
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_REG,
        FWD_MEM,
        FWD_WB
    } fwd_sel_e;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       rs1_data;
        logic [XLEN-1:0]       rs2_data;
        logic [XLEN-1:0]       imm;
        alu_op_e               alu_op;
        logic                  b_imm;
        logic                  reg_write;
        logic                  mem_read;
        logic                  mem_write;
        logic                  is_branch;
        logic                  bne;
    } id_ex_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       alu_res;
        logic [XLEN-1:0]       store_data;
        logic [REG_ADDR_W-1:0] rd;
        logic                  reg_write;
        logic                  mem_read;
        logic                  mem_write;
    } ex_mem_t;

endpackage

`default_nettype wire

// File: hw/rv_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface rv_ctrl_if;

    // Hazard sources, gathered from the stages.
    logic [rv_pkg::REG_ADDR_W-1:0] rs1_id;
    logic [rv_pkg::REG_ADDR_W-1:0] rs2_id;
    logic                          jal_id;
    logic [rv_pkg::REG_ADDR_W-1:0] rd_ex;
    logic                          mem_read_ex;
    logic                          branch_taken_ex;
    logic [rv_pkg::REG_ADDR_W-1:0] rs1_ex;
    logic [rv_pkg::REG_ADDR_W-1:0] rs2_ex;
    logic [rv_pkg::REG_ADDR_W-1:0] rd_mem;
    logic                          reg_write_mem;
    logic [rv_pkg::REG_ADDR_W-1:0] rd_wb;
    logic                          reg_write_wb;

    logic             stall_if;
    logic             stall_id;
    logic             flush_id;
    logic             flush_ex;
    logic             freeze; // The memory system is busy.
    rv_pkg::fwd_sel_e fwd_a;
    rv_pkg::fwd_sel_e fwd_b;

    modport ctrl (
        input  rs1_id, rs2_id, jal_id, rd_ex, mem_read_ex, branch_taken_ex, rs1_ex, rs2_ex,
        input  rd_mem, reg_write_mem, rd_wb, reg_write_wb,
        output stall_if, stall_id, flush_id, flush_ex, freeze, fwd_a, fwd_b
    );
    modport fetch (input stall_if, flush_id, freeze);
    modport decode (output rs1_id, rs2_id, jal_id, input stall_id, flush_id, flush_ex, freeze);
    modport execute (
        output rd_ex, mem_read_ex, branch_taken_ex, rs1_ex, rs2_ex,
        input  fwd_a, fwd_b, freeze
    );
    modport memwb (output rd_mem, reg_write_mem, rd_wb, reg_write_wb, input freeze);

endinterface

`default_nettype wire

// File: hw/rv_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module rv_fetch #(
    parameter logic [rv_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                    cpu_clk_i,
    input  logic                    rst_n_i,
    rv_ctrl_if.fetch                ctrl,
    input  logic                    branch_taken_i,
    input  logic                    jal_i,
    input  logic [rv_pkg::XLEN-1:0] branch_target_i,
    input  logic [rv_pkg::XLEN-1:0] jal_target_i,
    input  logic [rv_pkg::XLEN-1:0] inst_i,
    output logic [rv_pkg::XLEN-1:0] pc_o,
    output logic [rv_pkg::XLEN-1:0] if_id_pc_o,
    output logic [rv_pkg::XLEN-1:0] if_id_inst_o,
    output logic                    if_id_valid_o
);

    logic [rv_pkg::XLEN-1:0] next_pc;

    // An older taken branch overrides a JAL sitting in decode.
    assign next_pc = branch_taken_i ? branch_target_i :
                     jal_i          ? jal_target_i    : pc_o + 32'd4;

    always_ff @(posedge cpu_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_o          <= RESET_PC;
            if_id_valid_o <= 1'b0;
        end else if (!ctrl.freeze) begin
            if (!ctrl.stall_if) pc_o <= next_pc;
            if (ctrl.flush_id)
                if_id_valid_o <= 1'b0; // Drop the wrong-path fetch.
            else if (!ctrl.stall_if)
                if_id_valid_o <= 1'b1;
        end
    end

    always_ff @(posedge cpu_clk_i) begin
        if (!ctrl.stall_if) begin
            if_id_pc_o   <= pc_o;
            if_id_inst_o <= inst_i;
        end
    end

endmodule

`default_nettype wire

// File: hw/rv_decode.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decode (
    input  logic                          cpu_clk_i,
    input  logic                          rst_n_i,
    rv_ctrl_if.decode                     ctrl,
    input  logic [rv_pkg::XLEN-1:0]       if_id_pc_i,
    input  logic [rv_pkg::XLEN-1:0]       if_id_inst_i,
    input  logic                          if_id_valid_i,
    input  logic                          wb_we_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] wb_rd_i,
    input  logic [rv_pkg::XLEN-1:0]       wb_data_i,
    output logic                          jal_o,
    output logic [rv_pkg::XLEN-1:0]       jal_target_o,
    output rv_pkg::id_ex_t                id_ex_o
);

    logic [rv_pkg::XLEN-1:0]       regs [1:31];
    logic [rv_pkg::XLEN-1:0]       inst;
    logic [rv_pkg::XLEN-1:0]       imm_i, imm_s, imm_b, imm_u, imm_j;
    logic [rv_pkg::REG_ADDR_W-1:0] rs1, rs2;
    rv_pkg::id_ex_t                id_d;

    assign inst  = if_id_inst_i;
    assign rs1   = inst[19:15];
    assign rs2   = inst[24:20];
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // Unused source fields are left at zero so they never raise a hazard.
    always_comb begin
        id_d        = '0;
        id_d.valid  = if_id_valid_i;
        id_d.pc     = if_id_pc_i;
        id_d.rd     = inst[11:7];
        id_d.alu_op = rv_pkg::ALU_ADD;
        case (inst[6:0])
            rv_pkg::OP_REG: begin
                id_d.rs1       = rs1;
                id_d.rs2       = rs2;
                id_d.reg_write = 1'b1;
                case (inst[14:12])
                    3'b000:  id_d.alu_op = inst[30] ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
                    3'b010:  id_d.alu_op = rv_pkg::ALU_SLT;
                    3'b100:  id_d.alu_op = rv_pkg::ALU_XOR;
                    3'b110:  id_d.alu_op = rv_pkg::ALU_OR;
                    default: id_d.alu_op = rv_pkg::ALU_AND;
                endcase
            end
            rv_pkg::OP_IMM, rv_pkg::OP_LOAD: begin
                id_d.rs1       = rs1;
                id_d.imm       = imm_i;
                id_d.b_imm     = 1'b1;
                id_d.reg_write = 1'b1;
                id_d.mem_read  = (inst[6:0] == rv_pkg::OP_LOAD);
            end
            rv_pkg::OP_LUI: begin
                id_d.imm       = imm_u;
                id_d.b_imm     = 1'b1;
                id_d.alu_op    = rv_pkg::ALU_PASS_B;
                id_d.reg_write = 1'b1;
            end
            rv_pkg::OP_STORE: begin
                id_d.rs1       = rs1;
                id_d.rs2       = rs2;
                id_d.imm       = imm_s;
                id_d.b_imm     = 1'b1;
                id_d.mem_write = 1'b1;
            end
            rv_pkg::OP_BRANCH: begin
                id_d.rs1       = rs1;
                id_d.rs2       = rs2;
                id_d.imm       = imm_b;
                id_d.is_branch = 1'b1;
                id_d.bne       = inst[12];
            end
            rv_pkg::OP_JAL: begin
                id_d.imm       = if_id_pc_i + 32'd4; // Link value goes through the ALU.
                id_d.b_imm     = 1'b1;
                id_d.alu_op    = rv_pkg::ALU_PASS_B;
                id_d.reg_write = 1'b1;
            end
            default: ;
        endcase
        // Write-through, so a result retiring this cycle is seen here.
        if (wb_we_i && wb_rd_i == id_d.rs1 && id_d.rs1 != '0) id_d.rs1_data = wb_data_i;
        else if (id_d.rs1 != '0) id_d.rs1_data = regs[id_d.rs1];
        if (wb_we_i && wb_rd_i == id_d.rs2 && id_d.rs2 != '0) id_d.rs2_data = wb_data_i;
        else if (id_d.rs2 != '0) id_d.rs2_data = regs[id_d.rs2];
    end

    assign ctrl.rs1_id  = if_id_valid_i ? id_d.rs1 : '0;
    assign ctrl.rs2_id  = if_id_valid_i ? id_d.rs2 : '0;
    assign ctrl.jal_id  = if_id_valid_i && inst[6:0] == rv_pkg::OP_JAL;
    assign jal_o        = ctrl.jal_id && ctrl.flush_id && !ctrl.flush_ex;
    assign jal_target_o = if_id_pc_i + imm_j;

    always_ff @(posedge cpu_clk_i) begin
        if (wb_we_i && !ctrl.freeze && wb_rd_i != '0) regs[wb_rd_i] <= wb_data_i;
    end

    always_ff @(posedge cpu_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            id_ex_o <= '0;
        end else if (!ctrl.freeze) begin
            if (ctrl.flush_ex || ctrl.stall_id) id_ex_o <= '0; // Bubble.
            else id_ex_o <= id_d;
        end
    end

endmodule

`default_nettype wire

// File: hw/rv_execute.sv
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
    input  logic                    cpu_clk_i,
    input  logic                    rst_n_i,
    rv_ctrl_if.execute              ctrl,
    input  rv_pkg::id_ex_t          id_ex_i,
    input  logic [rv_pkg::XLEN-1:0] alu_mem_i,
    input  logic [rv_pkg::XLEN-1:0] result_wb_i,
    output logic                    branch_taken_o,
    output logic [rv_pkg::XLEN-1:0] branch_target_o,
    output rv_pkg::ex_mem_t         ex_mem_o
);

    logic [rv_pkg::XLEN-1:0] op_a, op_b_reg, op_b, alu_res;

    always_comb begin
        case (ctrl.fwd_a)
            rv_pkg::FWD_MEM: op_a = alu_mem_i;
            rv_pkg::FWD_WB:  op_a = result_wb_i;
            default:         op_a = id_ex_i.rs1_data;
        endcase
        case (ctrl.fwd_b)
            rv_pkg::FWD_MEM: op_b_reg = alu_mem_i;
            rv_pkg::FWD_WB:  op_b_reg = result_wb_i;
            default:         op_b_reg = id_ex_i.rs2_data;
        endcase
    end

    assign op_b = id_ex_i.b_imm ? id_ex_i.imm : op_b_reg;

    always_comb begin
        case (id_ex_i.alu_op)
            rv_pkg::ALU_ADD:    alu_res = op_a + op_b;
            rv_pkg::ALU_SUB:    alu_res = op_a - op_b;
            rv_pkg::ALU_AND:    alu_res = op_a & op_b;
            rv_pkg::ALU_OR:     alu_res = op_a | op_b;
            rv_pkg::ALU_XOR:    alu_res = op_a ^ op_b;
            rv_pkg::ALU_SLT:    alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            rv_pkg::ALU_PASS_B: alu_res = op_b;
            default:            alu_res = '0;
        endcase
    end

    // BNE inverts the equality test.
    assign branch_taken_o  = id_ex_i.valid && id_ex_i.is_branch &&
                             ((op_a == op_b_reg) ^ id_ex_i.bne);
    assign branch_target_o = id_ex_i.pc + id_ex_i.imm;

    assign ctrl.rd_ex           = id_ex_i.rd;
    assign ctrl.mem_read_ex     = id_ex_i.valid && id_ex_i.mem_read;
    assign ctrl.branch_taken_ex = branch_taken_o;
    assign ctrl.rs1_ex          = id_ex_i.rs1;
    assign ctrl.rs2_ex          = id_ex_i.rs2;

    always_ff @(posedge cpu_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_mem_o <= '0;
        end else if (!ctrl.freeze) begin
            ex_mem_o.valid      <= id_ex_i.valid;
            ex_mem_o.alu_res    <= alu_res;
            ex_mem_o.store_data <= op_b_reg; // Forwarded, not the stale register read.
            ex_mem_o.rd         <= id_ex_i.rd;
            ex_mem_o.reg_write  <= id_ex_i.reg_write;
            ex_mem_o.mem_read   <= id_ex_i.mem_read;
            ex_mem_o.mem_write  <= id_ex_i.mem_write;
        end
    end

endmodule

`default_nettype wire

// File: hw/rv_memwb.sv
`timescale 1ns/1ps
`default_nettype none

module rv_memwb (
    input  logic                          cpu_clk_i,
    input  logic                          rst_n_i,
    rv_ctrl_if.memwb                      ctrl,
    input  rv_pkg::ex_mem_t               ex_mem_i,
    output logic [rv_pkg::XLEN-1:0]       dmem_addr_o,
    output logic [rv_pkg::XLEN-1:0]       dmem_wdata_o,
    output logic                          dmem_we_o,
    input  logic [rv_pkg::XLEN-1:0]       dmem_rdata_i,
    output logic [rv_pkg::XLEN-1:0]       alu_mem_o,
    output logic                          wb_we_o,
    output logic [rv_pkg::REG_ADDR_W-1:0] wb_rd_o,
    output logic [rv_pkg::XLEN-1:0]       wb_data_o
);

    logic wb_valid_q;
    logic wb_reg_write_q;

    assign dmem_addr_o  = ex_mem_i.alu_res;
    assign dmem_wdata_o = ex_mem_i.store_data;
    assign dmem_we_o    = ex_mem_i.valid && ex_mem_i.mem_write;
    assign alu_mem_o    = ex_mem_i.alu_res;

    always_ff @(posedge cpu_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_valid_q     <= 1'b0;
            wb_reg_write_q <= 1'b0;
        end else if (!ctrl.freeze) begin
            wb_valid_q     <= ex_mem_i.valid;
            wb_reg_write_q <= ex_mem_i.reg_write;
        end
    end

    always_ff @(posedge cpu_clk_i) begin
        if (!ctrl.freeze) begin
            wb_rd_o   <= ex_mem_i.rd;
            wb_data_o <= ex_mem_i.mem_read ? dmem_rdata_i : ex_mem_i.alu_res;
        end
    end

    assign wb_we_o = wb_valid_q && wb_reg_write_q;

    assign ctrl.rd_mem        = ex_mem_i.rd;
    assign ctrl.reg_write_mem = ex_mem_i.valid && ex_mem_i.reg_write;
    assign ctrl.rd_wb         = wb_rd_o;
    assign ctrl.reg_write_wb  = wb_we_o;

endmodule

`default_nettype wire

// File: hw/rv_hazard_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module rv_hazard_ctrl (
    rv_ctrl_if.ctrl ctrl,
    input logic     mem_stall_i
);

    logic load_use;

    // A load in execute whose result the instruction in decode needs.
    assign load_use = ctrl.mem_read_ex && ctrl.rd_ex != '0 &&
                      (ctrl.rd_ex == ctrl.rs1_id || ctrl.rd_ex == ctrl.rs2_id);

    assign ctrl.freeze   = mem_stall_i;
    assign ctrl.stall_if = load_use || mem_stall_i;
    assign ctrl.stall_id = load_use || mem_stall_i;

    // The taken branch is older than the JAL, so it also clears the JAL.
    assign ctrl.flush_ex = !mem_stall_i && ctrl.branch_taken_ex;
    assign ctrl.flush_id = !mem_stall_i && (ctrl.branch_taken_ex || ctrl.jal_id);

    // The newer result in memory wins over the one in write-back.
    always_comb begin
        ctrl.fwd_a = rv_pkg::FWD_REG;
        if (ctrl.reg_write_mem && ctrl.rd_mem != '0 && ctrl.rd_mem == ctrl.rs1_ex)
            ctrl.fwd_a = rv_pkg::FWD_MEM;
        else if (ctrl.reg_write_wb && ctrl.rd_wb != '0 && ctrl.rd_wb == ctrl.rs1_ex)
            ctrl.fwd_a = rv_pkg::FWD_WB;

        ctrl.fwd_b = rv_pkg::FWD_REG;
        if (ctrl.reg_write_mem && ctrl.rd_mem != '0 && ctrl.rd_mem == ctrl.rs2_ex)
            ctrl.fwd_b = rv_pkg::FWD_MEM;
        else if (ctrl.reg_write_wb && ctrl.rd_wb != '0 && ctrl.rd_wb == ctrl.rs2_ex)
            ctrl.fwd_b = rv_pkg::FWD_WB;
    end

endmodule

`default_nettype wire

// File: hw/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core #(
    parameter logic [rv_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                    cpu_clk_i,
    input  logic                    rst_n_i,
    input  logic                    mem_stall_i,
    output logic [rv_pkg::XLEN-1:0] pc_o,
    input  logic [rv_pkg::XLEN-1:0] inst_i,
    output logic [rv_pkg::XLEN-1:0] dmem_addr_o,
    output logic [rv_pkg::XLEN-1:0] dmem_wdata_o,
    output logic                    dmem_we_o,
    input  logic [rv_pkg::XLEN-1:0] dmem_rdata_i
);

    rv_ctrl_if ctrl ();

    logic                          branch_taken, jal_id;
    logic [rv_pkg::XLEN-1:0]       branch_target, jal_target;
    logic [rv_pkg::XLEN-1:0]       if_id_pc, if_id_inst;
    logic                          if_id_valid;
    rv_pkg::id_ex_t                id_ex;
    rv_pkg::ex_mem_t               ex_mem;
    logic [rv_pkg::XLEN-1:0]       alu_mem, wb_data;
    logic                          wb_we;
    logic [rv_pkg::REG_ADDR_W-1:0] wb_rd;

    rv_fetch #(.RESET_PC(RESET_PC)) u_fetch (
        .cpu_clk_i, .rst_n_i, .ctrl(ctrl.fetch),
        .branch_taken_i(branch_taken), .jal_i(jal_id),
        .branch_target_i(branch_target), .jal_target_i(jal_target),
        .inst_i, .pc_o,
        .if_id_pc_o(if_id_pc), .if_id_inst_o(if_id_inst), .if_id_valid_o(if_id_valid)
    );

    rv_decode u_decode (
        .cpu_clk_i, .rst_n_i, .ctrl(ctrl.decode),
        .if_id_pc_i(if_id_pc), .if_id_inst_i(if_id_inst), .if_id_valid_i(if_id_valid),
        .wb_we_i(wb_we), .wb_rd_i(wb_rd), .wb_data_i(wb_data),
        .jal_o(jal_id), .jal_target_o(jal_target), .id_ex_o(id_ex)
    );

    rv_execute u_execute (
        .cpu_clk_i, .rst_n_i, .ctrl(ctrl.execute),
        .id_ex_i(id_ex), .alu_mem_i(alu_mem), .result_wb_i(wb_data),
        .branch_taken_o(branch_taken), .branch_target_o(branch_target), .ex_mem_o(ex_mem)
    );

    rv_memwb u_memwb (
        .cpu_clk_i, .rst_n_i, .ctrl(ctrl.memwb), .ex_mem_i(ex_mem),
        .dmem_addr_o, .dmem_wdata_o, .dmem_we_o, .dmem_rdata_i,
        .alu_mem_o(alu_mem), .wb_we_o(wb_we), .wb_rd_o(wb_rd), .wb_data_o(wb_data)
    );

    rv_hazard_ctrl u_hazard_ctrl (
        .ctrl(ctrl.ctrl),
        .mem_stall_i
    );

endmodule

`default_nettype wire

// File: sim/rv_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;

    localparam int NUM_TESTS = 6;
    localparam int PROG_W    = 20;
    localparam int MAX_ST    = 8;
    localparam int TIMEOUT   = 500;

    logic        cpu_clk_i;
    logic        rst_n_i     = 1'b0;
    logic        mem_stall_i = 1'b0;
    logic [31:0] pc_o, inst_i, dmem_addr_o, dmem_wdata_o, dmem_rdata_i;
    logic        dmem_we_o;

    logic [31:0] imem [64];
    logic [31:0] dmem [64];
    logic [31:0] prog_tab [NUM_TESTS][PROG_W];
    logic [31:0] exp_addr [NUM_TESTS][MAX_ST];
    logic [31:0] exp_data [NUM_TESTS][MAX_ST];
    int          prog_len [NUM_TESTS];
    int          exp_cnt [NUM_TESTS];
    bit          rand_stall [NUM_TESTS];
    string       test_name [NUM_TESTS];

    int cur_test, seen, checks, errors, bad_tests;
    bit stall_on;

    rv_core #(.RESET_PC(32'h0)) i_dut (
        .cpu_clk_i, .rst_n_i, .mem_stall_i, .pc_o, .inst_i,
        .dmem_addr_o, .dmem_wdata_o, .dmem_we_o, .dmem_rdata_i
    );

    // Both memories answer combinationally.
    assign inst_i       = imem[pc_o[7:2]];
    assign dmem_rdata_i = dmem[dmem_addr_o[7:2]];

    initial begin
        cpu_clk_i = 1'b0;
        forever #2 cpu_clk_i = ~cpu_clk_i;
    end

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rv_pkg::OP_REG};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2, rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_pkg::OP_STORE};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2, rs1,
                                           input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::OP_BRANCH};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, rv_pkg::OP_LUI};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::OP_JAL};
    endfunction

    function automatic logic [31:0] fill_word(input int idx);
        return 32'h5A00_0000 + idx * 32'h0001_0101;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got, exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR t=%0t %s got=%h exp=%h", $time, name, got, exp);
        end
    endtask

    task automatic add_inst(input int t, input logic [31:0] inst);
        prog_tab[t][prog_len[t]] = inst;
        prog_len[t]++;
    endtask

    task automatic expect_store(input int t, input logic [31:0] addr, data);
        exp_addr[t][exp_cnt[t]] = addr;
        exp_data[t][exp_cnt[t]] = data;
        exp_cnt[t]++;
    endtask

    // Back-to-back dependences, so most operands come through forwarding.
    task automatic alu_program(input int t);
        logic [31:0] a, b, r_add, r_sub, r_and, r_or, r_xor, r_slt, r_lui;
        a     = 32'd5;
        b     = 32'd0 - 32'd3;
        r_add = a + b;
        r_sub = r_add - a;
        r_and = r_sub & a;
        r_or  = r_and | b;
        r_xor = r_or ^ r_add;
        r_slt = ($signed(b) < $signed(a)) ? 32'd1 : 32'd0;
        r_lui = (32'h12345 << 12) + 32'h678;
        add_inst(t, i_type(12'd5, 5'd0, 3'd0, 5'd1, rv_pkg::OP_IMM));
        add_inst(t, i_type(12'hFFD, 5'd0, 3'd0, 5'd2, rv_pkg::OP_IMM)); // addi x2, x0, -3
        add_inst(t, r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
        add_inst(t, r_type(7'h20, 5'd1, 5'd3, 3'b000, 5'd4));
        add_inst(t, r_type(7'h00, 5'd1, 5'd4, 3'b111, 5'd5));
        add_inst(t, r_type(7'h00, 5'd2, 5'd5, 3'b110, 5'd6));
        add_inst(t, r_type(7'h00, 5'd3, 5'd6, 3'b100, 5'd7));
        add_inst(t, r_type(7'h00, 5'd1, 5'd2, 3'b010, 5'd8));
        add_inst(t, u_type(20'h12345, 5'd9));
        add_inst(t, i_type(12'h678, 5'd9, 3'd0, 5'd9, rv_pkg::OP_IMM));
        add_inst(t, s_type(12'd24, 5'd9, 5'd0)); // Store data straight from MEM.
        expect_store(t, 32'd24, r_lui);
        add_inst(t, s_type(12'd0, 5'd3, 5'd0));
        expect_store(t, 32'd0, r_add);
        add_inst(t, s_type(12'd4, 5'd4, 5'd0));
        expect_store(t, 32'd4, r_sub);
        add_inst(t, s_type(12'd8, 5'd5, 5'd0));
        expect_store(t, 32'd8, r_and);
        add_inst(t, s_type(12'd12, 5'd6, 5'd0));
        expect_store(t, 32'd12, r_or);
        add_inst(t, s_type(12'd16, 5'd7, 5'd0));
        expect_store(t, 32'd16, r_xor);
        add_inst(t, s_type(12'd20, 5'd8, 5'd0));
        expect_store(t, 32'd20, r_slt);
        add_inst(t, j_type(21'd0, 5'd0));
    endtask

    task automatic build_table();
        test_name = '{"alu_fwd", "load_use", "branch", "jal", "mem_stall", "x0"};
        rand_stall = '{0, 0, 0, 0, 1, 0};
        alu_program(0);
        alu_program(4);
        // Each loaded value feeds the very next instruction.
        add_inst(1, i_type(12'd32, 5'd0, 3'b010, 5'd1, rv_pkg::OP_LOAD));
        add_inst(1, i_type(12'd100, 5'd1, 3'd0, 5'd2, rv_pkg::OP_IMM));
        add_inst(1, s_type(12'd36, 5'd2, 5'd0));
        add_inst(1, i_type(12'd36, 5'd0, 3'b010, 5'd3, rv_pkg::OP_LOAD));
        add_inst(1, r_type(7'h00, 5'd1, 5'd3, 3'b000, 5'd4));
        add_inst(1, s_type(12'd40, 5'd4, 5'd0));
        add_inst(1, j_type(21'd0, 5'd0));
        expect_store(1, 32'd36, fill_word(8) + 32'd100);
        expect_store(1, 32'd40, fill_word(8) + 32'd100 + fill_word(8));
        // x1 and x2 are both 7, x3 is 1.
        add_inst(2, i_type(12'd7, 5'd0, 3'd0, 5'd1, rv_pkg::OP_IMM));
        add_inst(2, i_type(12'd7, 5'd0, 3'd0, 5'd2, rv_pkg::OP_IMM));
        add_inst(2, b_type(13'd12, 5'd2, 5'd1, 3'b000)); // Taken.
        add_inst(2, s_type(12'd64, 5'd1, 5'd0));
        add_inst(2, s_type(12'd68, 5'd1, 5'd0));
        add_inst(2, b_type(13'd8, 5'd2, 5'd1, 3'b001)); // Not taken.
        add_inst(2, s_type(12'd72, 5'd2, 5'd0));
        add_inst(2, i_type(12'd1, 5'd0, 3'd0, 5'd3, rv_pkg::OP_IMM));
        add_inst(2, b_type(13'd8, 5'd3, 5'd1, 3'b000)); // Not taken.
        add_inst(2, s_type(12'd76, 5'd3, 5'd0));
        add_inst(2, b_type(13'd8, 5'd3, 5'd1, 3'b001)); // Taken.
        add_inst(2, s_type(12'd80, 5'd3, 5'd0));
        add_inst(2, s_type(12'd84, 5'd1, 5'd0));
        add_inst(2, j_type(21'd0, 5'd0));
        expect_store(2, 32'd72, 32'd7);
        expect_store(2, 32'd76, 32'd1);
        expect_store(2, 32'd84, 32'd7);
        add_inst(3, i_type(12'd9, 5'd0, 3'd0, 5'd1, rv_pkg::OP_IMM));
        add_inst(3, j_type(21'd8, 5'd5));
        add_inst(3, s_type(12'd96, 5'd1, 5'd0));
        add_inst(3, s_type(12'd100, 5'd5, 5'd0));
        add_inst(3, j_type(21'd0, 5'd0));
        expect_store(3, 32'd100, 32'd4 + 32'd4); // The JAL sits at address 4.
        add_inst(5, i_type(12'd55, 5'd0, 3'd0, 5'd0, rv_pkg::OP_IMM));
        add_inst(5, s_type(12'd128, 5'd0, 5'd0));
        add_inst(5, u_type(20'hABCDE, 5'd0));
        add_inst(5, i_type(12'd3, 5'd0, 3'd0, 5'd1, rv_pkg::OP_IMM));
        add_inst(5, s_type(12'd132, 5'd1, 5'd0));
        add_inst(5, j_type(21'd0, 5'd0));
        expect_store(5, 32'd128, 32'd0);
        expect_store(5, 32'd132, 32'd0 + 32'd3);
    endtask

    always @(posedge cpu_clk_i) mem_stall_i <= stall_on && ($urandom % 3 == 0);

    // A store takes effect in a cycle without a memory stall.
    always @(negedge cpu_clk_i) begin
        if (rst_n_i && dmem_we_o && !mem_stall_i) begin
            dmem[dmem_addr_o[7:2]] = dmem_wdata_o;
            if (seen < exp_cnt[cur_test]) begin
                check_value("dmem_addr_o", dmem_addr_o, exp_addr[cur_test][seen]);
                check_value("dmem_wdata_o", dmem_wdata_o, exp_data[cur_test][seen]);
            end else begin
                errors++;
                $display("Unexpected store of %h to address %h in test %0d at %0t",
                         dmem_wdata_o, dmem_addr_o, cur_test, $time);
            end
            seen++;
        end
    end

    task automatic run_test(input int t);
        int          i;
        int          hits;
        int          cycles;
        int          err_before;
        logic [31:0] end_pc;
        err_before = errors;
        end_pc     = (prog_len[t] - 1) * 4; // The closing jump to itself.
        @(posedge cpu_clk_i);
        rst_n_i <= 1'b0;
        @(negedge cpu_clk_i);
        cur_test = t;
        seen     = 0;
        // In reset the core sits at its reset PC with no store pending.
        check_value("pc_o", pc_o, 32'h0);
        check_value("dmem_we_o", {31'b0, dmem_we_o}, 32'h0);
        for (i = 0; i < 64; i++) begin
            imem[i] = (i < prog_len[t]) ? prog_tab[t][i] :
                      i_type(i[11:0], 5'd0, 3'd0, 5'd0, rv_pkg::OP_IMM);
            dmem[i] = fill_word(i);
        end
        repeat (4) @(posedge cpu_clk_i);
        rst_n_i <= 1'b1;
        @(negedge cpu_clk_i);
        stall_on = rand_stall[t];
        hits     = 0;
        cycles   = 0;
        // The PC revisits the loop every other cycle, so four hits drain the pipeline.
        while (hits < 4 && cycles < TIMEOUT) begin
            @(negedge cpu_clk_i);
            cycles++;
            if (!mem_stall_i && pc_o == end_pc) hits++;
        end
        stall_on = 1'b0;
        @(posedge cpu_clk_i);
        if (hits < 4) begin
            errors++;
            $display("Test %0d timed out after %0d cycles before reaching its final loop",
                     t, cycles);
        end else if (seen < exp_cnt[t]) begin
            errors++;
            $display("Test %0d saw only %0d of %0d expected stores", t, seen, exp_cnt[t]);
        end
        if (errors == err_before) begin
            $display("test %0d %s: %0d stores, ok", t, test_name[t], seen);
        end else begin
            bad_tests++;
            $display("test %0d %s: %0d stores, %0d errors", t, test_name[t], seen,
                     errors - err_before);
        end
    endtask

    initial begin
        int t;
        void'($urandom(25920));
        build_table();
        for (t = 0; t < NUM_TESTS; t++) run_test(t);
        $display("tests: %0d, failing tests: %0d, checks: %0d, errors: %0d",
                 NUM_TESTS, bad_tests, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rv_core.f
hw/rv_pkg.sv
hw/rv_ctrl_if.sv
hw/rv_fetch.sv
hw/rv_decode.sv
hw/rv_execute.sv
hw/rv_memwb.sv
hw/rv_hazard_ctrl.sv
hw/rv_core.sv
sim/rv_core_tb.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - hw/rv_pkg.sv
  - hw/rv_ctrl_if.sv
  - hw/rv_fetch.sv
  - hw/rv_decode.sv
  - hw/rv_execute.sv
  - hw/rv_memwb.sv
  - hw/rv_hazard_ctrl.sv
  - hw/rv_core.sv
  - target: simulation
    files:
      - sim/rv_core_tb.sv
